// File: include/soc_defs.svh
// bus widths, map sizes and reset hold length
// for the SoC core.
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// data word and PI1 address widths.
`define ARCHBITSZ 32
`define ADDRBITSZ (`ARCHBITSZ - 2)
`define SELBITSZ (`ARCHBITSZ / 8)

// words mapped to each slave, in address order.
`define DEVTBL_MAPSZ 16
`define SRAM_MAPSZ 256
`define INVALID_MAPSZ 16

// devtbl, sram, default slave.
`define SLAVECOUNT 3

// reset sequencer.
`define RST_HOLD_CYCLES 16
`define RST_CNTR_BITSZ 5 // must hold RST_HOLD_CYCLES.

`endif

// File: logic/soc_pkg.sv
// PI1 operation, reset cause and software reset request types.

package soc_pkg;

	// PI1 operation codes.
	typedef enum logic [1:0] {
		NOOP = 2'b00,
		WROP = 2'b01,
		RDOP = 2'b10,
		RWOP = 2'b11 // swap: write new word, return old.
	} pi1_op_e;

	// why the system last left reset.
	typedef enum logic [1:0] {
		PWRON = 2'b00,
		WARM  = 2'b01,
		COLD  = 2'b10
	} rst_cause_e;

	// request from the two control bits {bit1, bit0}.
	typedef enum logic [1:0] {
		SWRST_NONE   = 2'b00,
		SWRST_PWROFF = 2'b01, // bit 0 only.
		SWRST_WARM   = 2'b10, // bit 1 only.
		SWRST_COLD   = 2'b11
	} swrst_e;

endpackage

// File: logic/pi1_if.sv
// PI1 peripheral bus with master and slave modports.
`timescale 1ns/1ps
`include "soc_defs.svh"

interface pi1_if;

	soc_pkg::pi1_op_e      op;    // held by the master until rdy.
	logic [`ADDRBITSZ-1:0] addr;  // word address, local to the slave.
	logic [`ARCHBITSZ-1:0] wdata;
	logic [`SELBITSZ-1:0]  sel;   // byte enables.
	logic [`ARCHBITSZ-1:0] rdata; // cycle after acceptance.
	logic                  rdy;

	// request side.
	modport master (
		output op,
		output addr,
		output wdata,
		output sel,
		input  rdata,
		input  rdy
	);

	// responding side.
	modport slave (
		input  op,
		input  addr,
		input  wdata,
		input  sel,
		output rdata,
		output rdy
	);

endinterface

// File: logic/rst_timer.sv
// reset hold down-counter.
`timescale 1ns/1ps
`include "soc_defs.svh"

module rst_timer (
	input  logic clk_w,
	input  logic rst_p,
	input  logic load_i,
	input  logic tick_en_i,
	output logic expired_o
);

	logic [`RST_CNTR_BITSZ-1:0] cnt_q;

	always_ff @(posedge clk_w) begin
		if (rst_p || load_i) begin
			cnt_q <= `RST_CNTR_BITSZ'(`RST_HOLD_CYCLES);
		end else if (tick_en_i && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1; // stops at zero.
		end
	end

	assign expired_o = (cnt_q == '0);

	// only a load may raise the count.
	a_no_wrap: assert property (@(posedge clk_w) disable iff (rst_p)
		!load_i |=> (cnt_q <= $past(cnt_q)));

endmodule

// File: logic/rst_ctrl_fsm.sv
// reset sequencer FSM for power-on, warm, cold and power-off.
`timescale 1ns/1ps
`include "soc_defs.svh"

module rst_ctrl_fsm (
	input  logic                clk_w,
	input  logic                rst_p,
	input  soc_pkg::swrst_e     swrst_i,
	input  logic                swrst_valid_i,
	input  logic                timer_expired_i,
	output logic                timer_load_o,
	output logic                timer_en_o,
	output logic                sys_rst_o,
	output logic                poweroff_o,
	output soc_pkg::rst_cause_e cause_o
);

	typedef enum logic [1:0] {
		ST_HOLD,
		ST_RUN,
		ST_OFF
	} state_e;

	state_e              state_q;
	state_e              state_d;
	soc_pkg::rst_cause_e cause_q;
	logic                sw_rst;
	logic                sw_off;

	// requests only count while running.
	assign sw_rst = (state_q == ST_RUN) && swrst_valid_i &&
		((swrst_i == soc_pkg::SWRST_WARM) || (swrst_i == soc_pkg::SWRST_COLD));
	assign sw_off = (state_q == ST_RUN) && swrst_valid_i &&
		(swrst_i == soc_pkg::SWRST_PWROFF);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_HOLD: begin
				if (timer_expired_i)
					state_d = ST_RUN;
			end
			ST_RUN: begin
				if (sw_off)
					state_d = ST_OFF;
				else if (sw_rst)
					state_d = ST_HOLD;
			end
			default: state_d = state_q; // off until rst_p.
		endcase
	end

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			state_q <= ST_HOLD;
			cause_q <= soc_pkg::PWRON;
		end else begin
			state_q <= state_d;
			if (sw_rst)
				cause_q <= (swrst_i == soc_pkg::SWRST_COLD) ? soc_pkg::COLD : soc_pkg::WARM;
		end
	end

	assign timer_load_o = sw_rst; // restart hold on entry.
	assign timer_en_o   = (state_q == ST_HOLD);
	assign sys_rst_o    = (state_q != ST_RUN);
	assign poweroff_o   = (state_q == ST_OFF);
	assign cause_o      = cause_q;

	a_off_sticky: assert property (@(posedge clk_w) disable iff (rst_p)
		poweroff_o |=> (poweroff_o && sys_rst_o));
	// every reset lasts at least the hold time.
	a_hold_len: assert property (@(posedge clk_w) disable iff (rst_p)
		$fell(sys_rst_o) |-> $past(sys_rst_o, `RST_HOLD_CYCLES));

endmodule

// File: logic/pi1_router.sv
// PI1 address decoder, response steering and the default slave.
`timescale 1ns/1ps
`include "soc_defs.svh"

module pi1_router (
	input  logic                  clk_w,
	input  logic                  rst_p,
	input  logic                  sys_rst_i,
	input  soc_pkg::pi1_op_e      op_i,
	input  logic [`ADDRBITSZ-1:0] addr_i,
	input  logic [`ARCHBITSZ-1:0] wdata_i,
	input  logic [`SELBITSZ-1:0]  sel_i,
	output logic [`ARCHBITSZ-1:0] rdata_o,
	output logic                  rdy_o,
	pi1_if.master                 s_bus [`SLAVECOUNT-1]
);

	localparam int DEV_IDX  = 0;
	localparam int SRAM_IDX = 1;
	localparam int DFLT_IDX = `SLAVECOUNT - 1; // built in, no bus.
	localparam int IDXW     = $clog2(`SLAVECOUNT);

	localparam logic [`ADDRBITSZ-1:0] SRAM_BASE = `DEVTBL_MAPSZ;
	localparam logic [`ADDRBITSZ-1:0] INV_BASE  = `DEVTBL_MAPSZ + `SRAM_MAPSZ;
	localparam logic [`ADDRBITSZ-1:0] SLV_BASE [`SLAVECOUNT-1] = '{'0, SRAM_BASE};

	logic [`SLAVECOUNT-1:0] sel_vec;
	logic [IDXW-1:0]        sel_idx;
	logic [IDXW-1:0]        idx_q;    // slave owing the data phase.
	logic [`ARCHBITSZ-1:0]  slv_rdata [`SLAVECOUNT];
	logic [`SLAVECOUNT-1:0] slv_rdy;

	// contiguous regions from 0, everything past sram is default.
	always_comb begin
		sel_vec = '0;
		if (addr_i < SRAM_BASE)
			sel_vec[DEV_IDX] = 1'b1;
		else if (addr_i < INV_BASE)
			sel_vec[SRAM_IDX] = 1'b1;
		else
			sel_vec[DFLT_IDX] = 1'b1;
	end

	always_comb begin
		sel_idx = '0;
		for (int i = 0; i < `SLAVECOUNT; i++) begin
			if (sel_vec[i])
				sel_idx = IDXW'(i);
		end
	end

	for (genvar i = 0; i < `SLAVECOUNT - 1; i++) begin : g_slv
		assign s_bus[i].op    = sel_vec[i] ? op_i : soc_pkg::NOOP;
		assign s_bus[i].addr  = addr_i - SLV_BASE[i];
		assign s_bus[i].wdata = wdata_i;
		assign s_bus[i].sel   = sel_i;
		assign slv_rdata[i]   = s_bus[i].rdata;
		assign slv_rdy[i]     = s_bus[i].rdy;
	end

	assign slv_rdata[DFLT_IDX] = '0;
	assign slv_rdy[DFLT_IDX]   = 1'b1;

	assign rdy_o = slv_rdy[sel_idx] && !sys_rst_i;

	always_ff @(posedge clk_w) begin
		if (rst_p)
			idx_q <= IDXW'(DFLT_IDX);
		else if (rdy_o && (op_i != soc_pkg::NOOP))
			idx_q <= sel_idx;
	end

	assign rdata_o = slv_rdata[idx_q];

	a_sel_onehot: assert property (@(posedge clk_w) disable iff (rst_p)
		(op_i != soc_pkg::NOOP) |-> $onehot(sel_vec));

endmodule

// File: logic/pi1_sram.sv
// single-port word SRAM slave with byte selects.
`timescale 1ns/1ps
`include "soc_defs.svh"

module pi1_sram (
	input logic  clk_w,
	input logic  sys_rst_i,
	pi1_if.slave bus
);

	localparam int IDXW = $clog2(`SRAM_MAPSZ);

	logic [`ARCHBITSZ-1:0] mem [`SRAM_MAPSZ];
	logic [`ARCHBITSZ-1:0] rdata_q;
	logic [IDXW-1:0]       idx;
	logic                  acc;
	logic                  do_wr;
	logic                  do_rd;

	assign idx   = bus.addr[IDXW-1:0];
	assign acc   = (bus.op != soc_pkg::NOOP) && !sys_rst_i;
	assign do_wr = acc && ((bus.op == soc_pkg::WROP) || (bus.op == soc_pkg::RWOP));
	assign do_rd = acc && ((bus.op == soc_pkg::RDOP) || (bus.op == soc_pkg::RWOP));

	always_ff @(posedge clk_w) begin
		if (do_rd)
			rdata_q <= mem[idx]; // old word on a swap.
		if (do_wr) begin
			for (int b = 0; b < `SELBITSZ; b++) begin
				if (bus.sel[b])
					mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
			end
		end
	end

	// contents kept across warm reset.
	assign bus.rdata = rdata_q;
	assign bus.rdy   = !sys_rst_i;

endmodule

// File: logic/devtbl.sv
// device table slave: map sizes, reset control word and reset cause.
`timescale 1ns/1ps
`include "soc_defs.svh"

module devtbl (
	input  logic                clk_w,
	input  logic                sys_rst_i,
	pi1_if.slave                bus,
	input  soc_pkg::rst_cause_e cause_i,
	output soc_pkg::swrst_e     swrst_o,
	output logic                swrst_valid_o
);

	localparam int IDXW = $clog2(`DEVTBL_MAPSZ);

	localparam logic [IDXW-1:0] W_DEVSZ  = 'd0;
	localparam logic [IDXW-1:0] W_SRAMSZ = 'd1;
	localparam logic [IDXW-1:0] W_INVSZ  = 'd2;
	localparam logic [IDXW-1:0] W_RSTCTL = 'd8;
	localparam logic [IDXW-1:0] W_CAUSE  = 'd9;

	logic [IDXW-1:0]       idx;
	logic                  acc;
	logic                  do_wr;
	logic                  do_rd;
	logic [`ARCHBITSZ-1:0] rd_word;
	logic [`ARCHBITSZ-1:0] rdata_q;

	assign idx   = bus.addr[IDXW-1:0];
	assign acc   = (bus.op != soc_pkg::NOOP) && !sys_rst_i;
	assign do_wr = acc && ((bus.op == soc_pkg::WROP) || (bus.op == soc_pkg::RWOP));
	assign do_rd = acc && ((bus.op == soc_pkg::RDOP) || (bus.op == soc_pkg::RWOP));

	always_comb begin
		rd_word = '0;
		case (idx)
			W_DEVSZ:  rd_word = `ARCHBITSZ'(`DEVTBL_MAPSZ);
			W_SRAMSZ: rd_word = `ARCHBITSZ'(`SRAM_MAPSZ);
			W_INVSZ:  rd_word = `ARCHBITSZ'(`INVALID_MAPSZ);
			W_CAUSE:  rd_word = `ARCHBITSZ'(cause_i);
			default:  rd_word = '0; // control word is write only.
		endcase
	end

	always_ff @(posedge clk_w) begin
		if (do_rd)
			rdata_q <= rd_word;
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy   = !sys_rst_i;

	// bit 1 only is warm, bit 0 only is power-off, both cold.
	assign swrst_o       = soc_pkg::swrst_e'(bus.wdata[1:0]);
	assign swrst_valid_o = do_wr && (idx == W_RSTCTL) && bus.sel[0] &&
		(swrst_o != soc_pkg::SWRST_NONE);

endmodule

// File: logic/soc_top.sv
// SoC core top: reset sequencer, PI1 router, SRAM and device table.
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top (
	input  logic                  clk_w,
	input  logic                  rst_p,
	input  soc_pkg::pi1_op_e      pi1_op_i,
	input  logic [`ADDRBITSZ-1:0] pi1_addr_i,
	input  logic [`ARCHBITSZ-1:0] pi1_data_i,
	input  logic [`SELBITSZ-1:0]  pi1_sel_i,
	output logic [`ARCHBITSZ-1:0] pi1_data_o,
	output logic                  pi1_rdy_o,
	output logic                  sys_rst_o,
	output logic                  poweroff_o
);

	logic                timer_load;
	logic                timer_en;
	logic                timer_expired;
	soc_pkg::swrst_e     swrst;
	logic                swrst_valid;
	soc_pkg::rst_cause_e cause;

	// slot 0 devtbl, slot 1 sram.
	pi1_if slv_bus [`SLAVECOUNT-1] ();

	rst_timer u_rst_timer (
		.clk_w     (clk_w),
		.rst_p     (rst_p),
		.load_i    (timer_load),
		.tick_en_i (timer_en),
		.expired_o (timer_expired)
	);

	rst_ctrl_fsm u_rst_ctrl (
		.clk_w           (clk_w),
		.rst_p           (rst_p),
		.swrst_i         (swrst),
		.swrst_valid_i   (swrst_valid),
		.timer_expired_i (timer_expired),
		.timer_load_o    (timer_load),
		.timer_en_o      (timer_en),
		.sys_rst_o       (sys_rst_o),
		.poweroff_o      (poweroff_o),
		.cause_o         (cause)
	);

	pi1_router u_router (
		.clk_w     (clk_w),
		.rst_p     (rst_p),
		.sys_rst_i (sys_rst_o),
		.op_i      (pi1_op_i),
		.addr_i    (pi1_addr_i),
		.wdata_i   (pi1_data_i),
		.sel_i     (pi1_sel_i),
		.rdata_o   (pi1_data_o),
		.rdy_o     (pi1_rdy_o),
		.s_bus     (slv_bus)
	);

	devtbl u_devtbl (
		.clk_w         (clk_w),
		.sys_rst_i     (sys_rst_o),
		.bus           (slv_bus[0]),
		.cause_i       (cause),
		.swrst_o       (swrst),
		.swrst_valid_o (swrst_valid)
	);

	pi1_sram u_sram (
		.clk_w     (clk_w),
		.sys_rst_i (sys_rst_o),
		.bus       (slv_bus[1])
	);

endmodule

// File: sim/soc_tb.sv
// testbench for soc_top: reset sequencing, PI1 routing,
// SRAM and device table checks against a reference model.
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_tb;

	localparam int N_RAND     = 400;
	localparam int SRAM_BASE  = `DEVTBL_MAPSZ;
	localparam int INV_BASE   = `DEVTBL_MAPSZ + `SRAM_MAPSZ;
	localparam int CTRL_WORD  = 8;
	localparam int CAUSE_WORD = 9;
	localparam int RST_SEQ    = 8 + `RST_HOLD_CYCLES + 4;
	// four resets, sram fill, random ops, reads after warm reset, power-off wait.
	localparam int TIMEOUT_CYCLES = 4 * RST_SEQ + `SRAM_MAPSZ + N_RAND + 64 +
		3 * `RST_HOLD_CYCLES + 300;

	logic                  clk_w;
	logic                  rst_p;
	soc_pkg::pi1_op_e      pi1_op_i;
	logic [`ADDRBITSZ-1:0] pi1_addr_i;
	logic [`ARCHBITSZ-1:0] pi1_data_i;
	logic [`SELBITSZ-1:0]  pi1_sel_i;
	logic [`ARCHBITSZ-1:0] pi1_data_o;
	logic                  pi1_rdy_o;
	logic                  sys_rst_o;
	logic                  poweroff_o;

	logic [`ARCHBITSZ-1:0] ref_mem [`SRAM_MAPSZ];
	soc_pkg::rst_cause_e   exp_cause;
	logic                  pend_vld; // read owed on the next negedge.
	logic [`ARCHBITSZ-1:0] pend_exp;
	int                    errors;
	int                    reads_checked;
	int                    cycles;
	int                    seed;

	soc_top dut (
		.clk_w      (clk_w),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.sys_rst_o  (sys_rst_o),
		.poweroff_o (poweroff_o)
	);

	initial begin
		clk_w = 1'b0;
		forever #4 clk_w = ~clk_w;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// expected read data from the memory map.
	function automatic logic [31:0] ref_read(input logic [`ADDRBITSZ-1:0] addr);
		logic [31:0] val;
		val = '0;
		if (addr < SRAM_BASE) begin
			case (addr)
				0:          val = `DEVTBL_MAPSZ;
				1:          val = `SRAM_MAPSZ;
				2:          val = `INVALID_MAPSZ;
				CAUSE_WORD: val = 32'(exp_cause);
				default:    val = '0;
			endcase
		end else if (addr < INV_BASE) begin
			val = ref_mem[addr - SRAM_BASE];
		end
		return val;
	endfunction

	function automatic void apply_write(input logic [`ADDRBITSZ-1:0] addr,
		input logic [31:0] data, input logic [3:0] sel);
		int idx;
		if (addr >= SRAM_BASE && addr < INV_BASE) begin
			idx = addr - SRAM_BASE;
			for (int b = 0; b < `SELBITSZ; b++) begin
				if (sel[b])
					ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
			end
		end else if (addr == CTRL_WORD && sel[0]) begin
			if (data[1:0] == 2'b11)
				exp_cause = soc_pkg::COLD;
			else if (data[1:0] == 2'b10)
				exp_cause = soc_pkg::WARM; // power-off leaves the cause alone.
		end
	endfunction

	// compare process, inputs and outputs are settled at the negedge.
	always @(negedge clk_w) begin
		if (rst_p) begin
			exp_cause = soc_pkg::PWRON;
			pend_vld  = 1'b0;
		end else begin
			if (pend_vld) begin
				check_val("pi1_data_o", pend_exp, pi1_data_o);
				reads_checked++;
			end
			pend_vld = 1'b0;
			if (pi1_rdy_o === 1'b1 && pi1_op_i != soc_pkg::NOOP) begin
				if (pi1_op_i == soc_pkg::RDOP || pi1_op_i == soc_pkg::RWOP) begin
					pend_exp = ref_read(pi1_addr_i); // old word on a swap.
					pend_vld = 1'b1;
				end
				if (pi1_op_i == soc_pkg::WROP || pi1_op_i == soc_pkg::RWOP)
					apply_write(pi1_addr_i, pi1_data_i, pi1_sel_i);
			end
		end
	end

	always @(posedge clk_w) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// drive one request and hold it until accepted.
	task automatic issue(input soc_pkg::pi1_op_e op, input logic [`ADDRBITSZ-1:0] addr,
		input logic [31:0] data, input logic [3:0] sel);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i  = sel;
		@(negedge clk_w);
		check_val("pi1_rdy_o", 1'b1, pi1_rdy_o); // every slave ready while running.
		while (pi1_rdy_o !== 1'b1)
			@(negedge clk_w);
		@(posedge clk_w);
		#1;
	endtask

	task automatic idle();
		pi1_op_i  = soc_pkg::NOOP;
		pi1_sel_i = '0;
	endtask

	task automatic read_word(input logic [`ADDRBITSZ-1:0] addr);
		issue(soc_pkg::RDOP, addr, '0, 4'hf);
	endtask

	// counts edges after the load edge that leave sys_rst_o high.
	task automatic check_hold();
		int n;
		n = 0;
		check_val("sys_rst_o", 1'b1, sys_rst_o);
		while (sys_rst_o === 1'b1) begin
			check_val("pi1_rdy_o", 1'b0, pi1_rdy_o);
			@(posedge clk_w);
			#1;
			if (sys_rst_o === 1'b1)
				n++;
		end
		check_val("hold cycles", `RST_HOLD_CYCLES, n);
		check_val("pi1_rdy_o", 1'b1, pi1_rdy_o);
	endtask

	task automatic rand_sram_ops(input int n);
		int                    k;
		logic [`ADDRBITSZ-1:0] a;
		logic [31:0]           d;
		logic [3:0]            s;
		soc_pkg::pi1_op_e      op;
		for (int i = 0; i < n; i++) begin
			k = {$random(seed)} % 3;
			a = SRAM_BASE + ({$random(seed)} % 64); // small window, more reuse.
			d = $random(seed);
			s = $random(seed);
			op = (k == 0) ? soc_pkg::WROP : (k == 1) ? soc_pkg::RDOP : soc_pkg::RWOP;
			issue(op, a, d, s);
		end
		idle();
	endtask

	initial begin
		seed          = 37166;
		errors        = 0;
		reads_checked = 0;
		cycles        = 0;
		pend_vld      = 1'b0;
		exp_cause     = soc_pkg::PWRON;
		rst_p         = 1'b1;
		pi1_op_i      = soc_pkg::NOOP;
		pi1_addr_i    = '0;
		pi1_data_i    = '0;
		pi1_sel_i     = '0;

		// power-on reset.
		repeat (8) @(posedge clk_w);
		#1;
		rst_p = 1'b0;
		check_hold();
		read_word(CAUSE_WORD);

		// fill sram, then random traffic.
		for (int i = 0; i < `SRAM_MAPSZ; i++)
			issue(soc_pkg::WROP, SRAM_BASE + i, (i * 32'h0100_0193) ^ 32'hc3a5_5a3c, 4'hf);
		rand_sram_ops(N_RAND);

		// device table and the default slave.
		for (int i = 0; i < 10; i++)
			read_word(i);
		for (int i = INV_BASE; i < INV_BASE + `INVALID_MAPSZ; i += 5)
			read_word(i);
		read_word(INV_BASE + `INVALID_MAPSZ + 3);
		read_word({`ADDRBITSZ{1'b1}});
		idle();

		// warm reset keeps sram.
		issue(soc_pkg::WROP, CTRL_WORD, 32'h2, 4'hf);
		idle();
		check_hold();
		for (int i = 0; i < `SRAM_MAPSZ; i += 4)
			read_word(SRAM_BASE + i);
		read_word(CAUSE_WORD);
		idle();

		// cold reset.
		issue(soc_pkg::WROP, CTRL_WORD, 32'h3, 4'hf);
		idle();
		check_hold();
		read_word(CAUSE_WORD);
		idle();

		// power-off holds until rst_p.
		issue(soc_pkg::WROP, CTRL_WORD, 32'h1, 4'hf);
		idle();
		repeat (3 * `RST_HOLD_CYCLES) begin
			check_val("poweroff_o", 1'b1, poweroff_o);
			check_val("sys_rst_o", 1'b1, sys_rst_o);
			check_val("pi1_rdy_o", 1'b0, pi1_rdy_o);
			@(posedge clk_w);
			#1;
		end
		rst_p = 1'b1;
		repeat (8) @(posedge clk_w);
		#1;
		check_val("poweroff_o", 1'b0, poweroff_o);
		rst_p = 1'b0;
		check_hold();
		read_word(CAUSE_WORD);
		idle();

		repeat (4) @(posedge clk_w);
		$display("done: %0d reads compared, %0d errors", reads_checked, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: files.f
+incdir+include
logic/soc_pkg.sv
logic/pi1_if.sv
logic/rst_timer.sv
logic/rst_ctrl_fsm.sv
logic/pi1_router.sv
logic/pi1_sram.sv
logic/devtbl.sv
logic/soc_top.sv
sim/soc_tb.sv
